// ==== verilog/blimp_pkg.sv ====
// ----------------------------------------------------------
// Shared constants and types for the Blimp core
// Memory request/response and trace records, fetch buffer
// sizing, RV32 opcode and funct constants
// ----------------------------------------------------------

`default_nettype none

package blimp_pkg;

  // ----------------------------------------------------------
  // Sizing
  // ----------------------------------------------------------

  // Fetch tag width, 4 distinct tags
  localparam int OPAQ_BITS   = 2;
  // Most fetches in flight or buffered
  localparam int FETCH_DEPTH = 2;
  // Buffer slot index width, slot is tag modulo depth
  localparam int SLOT_BITS   = $clog2(FETCH_DEPTH);

  // First fetch address out of reset
  localparam logic [31:0] RESET_PC = 32'h0000_0000;

  // ----------------------------------------------------------
  // RV32 encodings
  // ----------------------------------------------------------

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] FUNCT7_ADD = 7'b0000000;
  localparam logic [6:0] FUNCT7_MUL = 7'b0000001;
  // ADD, ADDI and MUL all share funct3 zero
  localparam logic [2:0] FUNCT3_ADD = 3'b000;
  localparam logic [2:0] FUNCT3_MUL = 3'b000;

  // ----------------------------------------------------------
  // Message structs
  // ----------------------------------------------------------

  // Fetch request, tag comes back with the response
  typedef struct packed {
    logic [OPAQ_BITS-1:0] opaque;
    logic [31:0]          addr;
  } mem_req_t;

  // Fetch response, carries the instruction word
  typedef struct packed {
    logic [OPAQ_BITS-1:0] opaque;
    logic [31:0]          data;
  } mem_resp_t;

  // Fetched instruction handed to execute
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] word;
  } inst_t;

  // One record per retired instruction
  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        wen;
  } trace_t;

endpackage

`default_nettype wire

// ==== verilog/blimp_regfile.sv ====
// ----------------------------------------------------------
// Integer register file, 32 x 32
// Two async read ports, one sync write port, x0 fixed zero
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module blimp_regfile (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  raddr0,
  input  logic [4:0]  raddr1,
  output logic [31:0] rdata0,
  output logic [31:0] rdata1,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata,
  input  logic        wen
);

  logic [31:0] regs [32];

  // Write port, x0 never updated
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // ----------------------------------------------------------
  // Read ports
  // ----------------------------------------------------------

  // x0 forced to zero
  assign rdata0 = (raddr0 == 5'd0) ? 32'd0 : regs[raddr0];
  assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];

endmodule

`default_nettype wire

// ==== verilog/blimp_fetch.sv ====
// ----------------------------------------------------------
// Instruction fetch unit
// Tagged sequential requests, up to two in flight, and an
// in-order buffer indexed by tag
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module blimp_fetch import blimp_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  output mem_req_t  mem_req,
  output logic      mem_req_val,
  input  logic      mem_req_rdy,
  input  mem_resp_t mem_resp,
  input  logic      mem_resp_val,
  output logic      mem_resp_rdy,
  output inst_t     inst,
  output logic      inst_val,
  input  logic      inst_rdy
);

  logic [31:0]          next_pc;
  logic [OPAQ_BITS-1:0] tag_q;
  logic [SLOT_BITS-1:0] head;
  logic                 run_q;

  // Per-slot state
  logic [FETCH_DEPTH-1:0] slot_busy;
  logic [FETCH_DEPTH-1:0] slot_filled;
  logic [31:0]            slot_pc   [FETCH_DEPTH];
  logic [31:0]            slot_word [FETCH_DEPTH];

  logic [SLOT_BITS-1:0] req_slot;
  logic [SLOT_BITS-1:0] resp_slot;
  logic                 req_go;
  logic                 resp_go;
  logic                 pop;

  // Slot for a tag is its low bits
  assign req_slot  = tag_q[SLOT_BITS-1:0];
  assign resp_slot = mem_resp.opaque[SLOT_BITS-1:0];

  // ----------------------------------------------------------
  // Request side
  // ----------------------------------------------------------

  // Offer only when the next tag's slot is free; stays put under back-pressure
  assign mem_req_val    = run_q && !slot_busy[req_slot];
  assign mem_req.opaque = tag_q;
  assign mem_req.addr   = next_pc;
  assign req_go         = mem_req_val && mem_req_rdy;

  // Every outstanding tag owns a slot, so responses always fit
  assign mem_resp_rdy = 1'b1;
  assign resp_go      = mem_resp_val && mem_resp_rdy;

  // Oldest slot goes out once its word is back
  assign inst_val  = slot_filled[head];
  assign inst.pc   = slot_pc[head];
  assign inst.word = slot_word[head];
  assign pop       = inst_val && inst_rdy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      next_pc     <= RESET_PC;
      tag_q       <= '0;
      head        <= '0;
      run_q       <= 1'b0;
      slot_busy   <= '0;
      slot_filled <= '0;
    end else begin
      // Hold off requests for the first cycle out of reset
      run_q <= 1'b1;
      if (req_go) begin
        slot_busy[req_slot] <= 1'b1;
        next_pc             <= next_pc + 32'd4;
        tag_q               <= tag_q + 1'b1;
      end
      if (resp_go) begin
        slot_filled[resp_slot] <= 1'b1;
      end
      // Release never collides with an allocate or a fill of the same slot
      if (pop) begin
        slot_busy[head]   <= 1'b0;
        slot_filled[head] <= 1'b0;
        head              <= head + 1'b1;
      end
    end
  end

  // Buffer payload
  always_ff @(posedge clk) begin
    if (req_go) begin
      slot_pc[req_slot] <= next_pc;
    end
    if (resp_go) begin
      slot_word[resp_slot] <= mem_resp.data;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/blimp_execute.sv ====
// ----------------------------------------------------------
// Execute stage
// Decode, ADD/ADDI/MUL datapath, register writeback and
// the registered trace record
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module blimp_execute import blimp_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  inst_t       inst,
  input  logic        inst_val,
  output logic        inst_rdy,
  output logic [4:0]  raddr0,
  output logic [4:0]  raddr1,
  input  logic [31:0] rdata0,
  input  logic [31:0] rdata1,
  output logic [4:0]  waddr,
  output logic [31:0] wdata,
  output logic        wen,
  output trace_t      trace,
  output logic        trace_val
);

  // Instruction fields
  logic [6:0]  opcode;
  logic [4:0]  rd;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;

  logic        is_add;
  logic        is_addi;
  logic        is_mul;
  logic        fire;
  logic [31:0] result;

  assign opcode = inst.word[6:0];
  assign rd     = inst.word[11:7];
  assign funct3 = inst.word[14:12];
  assign funct7 = inst.word[31:25];
  // Sign-extended I-type immediate
  assign imm_i  = {{20{inst.word[31]}}, inst.word[31:20]};

  // Register sources straight from the word
  assign raddr0 = inst.word[19:15];
  assign raddr1 = inst.word[24:20];

  // ----------------------------------------------------------
  // Decode
  // ----------------------------------------------------------

  assign is_addi = (opcode == OPC_OP_IMM) && (funct3 == FUNCT3_ADD);
  assign is_add  = (opcode == OPC_OP) && (funct3 == FUNCT3_ADD) && (funct7 == FUNCT7_ADD);
  assign is_mul  = (opcode == OPC_OP) && (funct3 == FUNCT3_MUL) && (funct7 == FUNCT7_MUL);

  // Single cycle per instruction, never stalls
  assign inst_rdy = 1'b1;
  assign fire     = inst_val && inst_rdy;

  // Wrapping sum, or low word of the product
  always_comb begin
    result = 32'd0;
    if (is_addi) begin
      result = rdata0 + imm_i;
    end else if (is_add) begin
      result = rdata0 + rdata1;
    end else if (is_mul) begin
      result = rdata0 * rdata1;
    end
  end

  // Writeback in the accept cycle, next instruction sees it
  assign waddr = rd;
  assign wdata = result;
  assign wen   = fire && (is_add || is_addi || is_mul) && (rd != 5'd0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      trace_val <= 1'b0;
    end else begin
      trace_val <= fire;
    end
  end

  // Trace payload
  always_ff @(posedge clk) begin
    if (fire) begin
      trace.pc    <= inst.pc;
      trace.waddr <= waddr;
      trace.wdata <= wdata;
      trace.wen   <= wen;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/blimp_core.sv ====
// ----------------------------------------------------------
// Blimp core top level
// Fetch, execute and register file on one memory port
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module blimp_core import blimp_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  // Instruction memory request
  output mem_req_t  mem_req,
  output logic      mem_req_val,
  input  logic      mem_req_rdy,
  // Instruction memory response
  input  mem_resp_t mem_resp,
  input  logic      mem_resp_val,
  output logic      mem_resp_rdy,
  // Retire trace
  output trace_t    trace,
  output logic      trace_val
);

  // ----------------------------------------------------------
  // Internal wiring
  // ----------------------------------------------------------

  // Fetch to execute
  inst_t       inst;
  logic        inst_val;
  logic        inst_rdy;

  // Execute to register file
  logic [4:0]  raddr0;
  logic [4:0]  raddr1;
  logic [31:0] rdata0;
  logic [31:0] rdata1;
  logic [4:0]  waddr;
  logic [31:0] wdata;
  logic        wen;

  // ----------------------------------------------------------
  // Instances
  // ----------------------------------------------------------

  blimp_fetch u_fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_req      (mem_req),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp     (mem_resp),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy),
    .inst         (inst),
    .inst_val     (inst_val),
    .inst_rdy     (inst_rdy)
  );

  blimp_execute u_execute (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst      (inst),
    .inst_val  (inst_val),
    .inst_rdy  (inst_rdy),
    .raddr0    (raddr0),
    .raddr1    (raddr1),
    .rdata0    (rdata0),
    .rdata1    (rdata1),
    .waddr     (waddr),
    .wdata     (wdata),
    .wen       (wen),
    .trace     (trace),
    .trace_val (trace_val)
  );

  blimp_regfile u_regfile (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr0 (raddr0),
    .raddr1 (raddr1),
    .rdata0 (rdata0),
    .rdata1 (rdata1),
    .waddr  (waddr),
    .wdata  (wdata),
    .wen    (wen)
  );

endmodule

`default_nettype wire

// ==== sim/blimp_core_chk.sv ====
// ----------------------------------------------------------
// Port assertions for the Blimp core
// Request hold, quiet trace in reset, fetch depth
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module blimp_core_chk import blimp_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input mem_req_t mem_req,
  input logic     mem_req_val,
  input logic     mem_req_rdy,
  input logic     mem_resp_val,
  input logic     mem_resp_rdy,
  input logic     trace_val
);

  // Fetches sent and not yet answered
  int outstanding;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(mem_req_val && mem_req_rdy)
                     - int'(mem_resp_val && mem_resp_rdy);
    end
  end

  // Stalled request keeps its payload
  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_val && !mem_req_rdy |=> mem_req_val && $stable(mem_req))
    else $error("mem_req changed or dropped while stalled");

  // Reset edge leaves trace quiet
  reset_quiet: assert property (@(posedge clk) !rst_n |=> !trace_val)
    else $error("trace_val high during reset");

  fetch_depth: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding <= FETCH_DEPTH)
    else $error("more fetches outstanding than buffer slots");

endmodule

`default_nettype wire

// ==== sim/blimp_core_tb.sv ====
// ----------------------------------------------------------
// Testbench for the Blimp core
// Program table, delayed out-of-order instruction memory,
// request address checks and trace record checks
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module blimp_core_tb import blimp_pkg::*; ();

  localparam int N_TESTS     = 19;
  localparam int CYCLE_LIMIT = 40 * N_TESTS + 50;
  // addi x0, x0, 0 served past the end of the program
  localparam logic [31:0] NOP_WORD = 32'h0000_0013;

  logic      clk;
  logic      rst_n;
  mem_req_t  mem_req;
  logic      mem_req_val;
  logic      mem_req_rdy;
  mem_resp_t mem_resp;
  logic      mem_resp_val;
  logic      mem_resp_rdy;
  trace_t    trace;
  logic      trace_val;

  // Program words and expected trace records
  logic [31:0] prog_word  [N_TESTS];
  trace_t      exp_trace  [N_TESTS];
  bit          check_data [N_TESTS];
  int          n_loaded = 0;

  // Accepted fetch waiting for its release cycle
  typedef struct packed {
    mem_req_t req;
    int       due;
  } pend_t;

  pend_t pend_q [$];
  int    cycle_count = 0;
  int    req_errors  = 0;
  int    pass_count  = 0;
  int    fail_count  = 0;

  blimp_core DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_req      (mem_req),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp     (mem_resp),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy),
    .trace        (trace),
    .trace_val    (trace_val)
  );

  bind blimp_core blimp_core_chk u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_req      (mem_req),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy),
    .trace_val    (trace_val)
  );

  // ----------------------------------------------------------
  // Encoding helpers and program table
  // ----------------------------------------------------------

  function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] rtype_word(input logic [6:0] funct7, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2);
    return {funct7, rs2, rs1, 3'b000, rd, OPC_OP};
  endfunction

  task automatic add_entry(input logic [31:0] word, input logic [4:0] rd,
                           input logic [31:0] wdata, input logic wen, input bit care);
    prog_word[n_loaded]       = word;
    exp_trace[n_loaded].pc    = RESET_PC + 32'(4 * n_loaded);
    exp_trace[n_loaded].waddr = rd;
    exp_trace[n_loaded].wdata = wdata;
    exp_trace[n_loaded].wen   = wen;
    check_data[n_loaded]      = care;
    n_loaded++;
  endtask

  // Expected values are hand computed wrapping sums and low product words
  task automatic load_program();
    add_entry(addi_word(5'd1, 5'd0, 12'd5),   5'd1, 32'h0000_0005, 1'b1, 1'b1);
    // -3 and -10
    add_entry(addi_word(5'd2, 5'd1, 12'hFFD), 5'd2, 32'h0000_0002, 1'b1, 1'b1);
    add_entry(addi_word(5'd3, 5'd2, 12'hFF6), 5'd3, 32'hFFFF_FFF8, 1'b1, 1'b1);
    // Write to x0 is dropped
    add_entry(addi_word(5'd0, 5'd1, 12'd7),   5'd0, 32'h0000_000C, 1'b0, 1'b1);
    add_entry(addi_word(5'd4, 5'd0, 12'h7FF), 5'd4, 32'h0000_07FF, 1'b1, 1'b1);
    // 2047 - 2048
    add_entry(addi_word(5'd17, 5'd4, 12'h800), 5'd17, 32'hFFFF_FFFF, 1'b1, 1'b1);
    add_entry(rtype_word(FUNCT7_ADD, 5'd5, 5'd1, 5'd2), 5'd5, 32'h0000_0007, 1'b1, 1'b1);
    add_entry(rtype_word(FUNCT7_ADD, 5'd6, 5'd5, 5'd5), 5'd6, 32'h0000_000E, 1'b1, 1'b1);
    // 14 * -8
    add_entry(rtype_word(FUNCT7_MUL, 5'd7, 5'd6, 5'd3), 5'd7, 32'hFFFF_FF90, 1'b1, 1'b1);
    add_entry(rtype_word(FUNCT7_MUL, 5'd13, 5'd4, 5'd4), 5'd13, 32'h003F_F001, 1'b1, 1'b1);
    // Product overflows 32 bits
    add_entry(rtype_word(FUNCT7_MUL, 5'd14, 5'd13, 5'd13), 5'd14, 32'h017F_E001, 1'b1, 1'b1);
    add_entry(rtype_word(FUNCT7_MUL, 5'd15, 5'd14, 5'd3), 5'd15, 32'hF400_FFF8, 1'b1, 1'b1);
    // LUI x9 is unsupported, no write
    add_entry(32'h1234_54B7, 5'd9, 32'h0000_0000, 1'b0, 1'b0);
    add_entry(rtype_word(FUNCT7_ADD, 5'd8, 5'd9, 5'd1), 5'd8, 32'h0000_0005, 1'b1, 1'b1);
    add_entry(addi_word(5'd10, 5'd0, 12'd1), 5'd10, 32'h0000_0001, 1'b1, 1'b1);
    add_entry(rtype_word(FUNCT7_ADD, 5'd16, 5'd17, 5'd10), 5'd16, 32'h0000_0000, 1'b1, 1'b1);
    add_entry(rtype_word(FUNCT7_MUL, 5'd18, 5'd17, 5'd17), 5'd18, 32'h0000_0001, 1'b1, 1'b1);
    add_entry(rtype_word(FUNCT7_ADD, 5'd0, 5'd1, 5'd1), 5'd0, 32'h0000_000A, 1'b0, 1'b1);
    add_entry(rtype_word(FUNCT7_ADD, 5'd21, 5'd0, 5'd1), 5'd21, 32'h0000_0005, 1'b1, 1'b1);
  endtask

  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    int idx;
    idx = int'((addr - RESET_PC) >> 2);
    if (idx >= 0 && idx < N_TESTS) begin
      return prog_word[idx];
    end
    return NOP_WORD;
  endfunction

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------

  task automatic check_req(input mem_req_t got, input mem_req_t exp);
    if (got.addr !== exp.addr) begin
      $display("ERROR at %0t: mem_req.addr got %h expected %h", $time, got.addr, exp.addr);
      req_errors++;
    end
    if (got.opaque !== exp.opaque) begin
      $display("ERROR at %0t: mem_req.opaque got %h expected %h", $time, got.opaque,
               exp.opaque);
      req_errors++;
    end
  endtask

  task automatic check_trace(input trace_t got, input trace_t exp, input bit care,
                             output bit ok);
    ok = 1'b1;
    if (got.pc !== exp.pc) begin
      $display("ERROR at %0t: trace.pc got %h expected %h", $time, got.pc, exp.pc);
      ok = 1'b0;
    end
    if (got.waddr !== exp.waddr) begin
      $display("ERROR at %0t: trace.waddr got %0d expected %0d", $time, got.waddr, exp.waddr);
      ok = 1'b0;
    end
    if (got.wen !== exp.wen) begin
      $display("ERROR at %0t: trace.wen got %b expected %b", $time, got.wen, exp.wen);
      ok = 1'b0;
    end
    if (care && got.wdata !== exp.wdata) begin
      $display("ERROR at %0t: trace.wdata got %h expected %h", $time, got.wdata, exp.wdata);
      ok = 1'b0;
    end
  endtask

  // ----------------------------------------------------------
  // Clock, cycle limit, memory model
  // ----------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("Timeout: trace stream incomplete after %0d cycles", CYCLE_LIMIT);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin : mem_model
    logic [31:0]          exp_addr;
    logic [OPAQ_BITS-1:0] exp_tag;
    mem_req_t             req_cap;
    mem_req_t             exp_req;
    pend_t                entry;
    bit                   live;
    bit                   got_req;
    bit                   resp_done;
    bit                   presenting;
    int                   first;
    int                   second;
    int                   pick;
    void'($urandom(38853));
    exp_addr     = RESET_PC;
    exp_tag      = '0;
    presenting   = 1'b0;
    mem_req_rdy  = 1'b0;
    mem_resp     = '0;
    mem_resp_val = 1'b0;
    forever begin
      @(posedge clk);
      // Handshakes as seen on the edge
      live      = rst_n;
      got_req   = live && mem_req_val && mem_req_rdy;
      resp_done = live && mem_resp_val && mem_resp_rdy;
      if (got_req) begin
        exp_req.opaque = exp_tag;
        exp_req.addr   = exp_addr;
        check_req(mem_req, exp_req);
        req_cap  = mem_req;
        exp_addr = exp_addr + 32'd4;
        exp_tag  = exp_tag + OPAQ_BITS'(1);
      end
      #1;
      // Delay of 0 to 3 cycles per fetch
      if (got_req) begin
        entry.req = req_cap;
        entry.due = cycle_count + int'($urandom % 4);
        pend_q.push_back(entry);
      end
      if (resp_done) begin
        presenting = 1'b0;
      end
      mem_req_rdy = live && (($urandom % 4) != 0);
      if (!presenting) begin
        first  = -1;
        second = -1;
        foreach (pend_q[i]) begin
          if (pend_q[i].due <= cycle_count) begin
            if (first < 0) begin
              first = i;
            end else if (second < 0) begin
              second = i;
            end
          end
        end
        mem_resp_val = 1'b0;
        if (first >= 0) begin
          // Two ready fetches may swap places
          pick = ((second >= 0) && ($urandom % 2 == 1)) ? second : first;
          mem_resp.opaque = pend_q[pick].req.opaque;
          mem_resp.data   = fetch_word(pend_q[pick].req.addr);
          mem_resp_val    = 1'b1;
          presenting      = 1'b1;
          pend_q.delete(pick);
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Reset and trace checking
  // ----------------------------------------------------------

  initial begin : main
    bit ok;
    rst_n = 1'b0;
    load_program();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // One retire per table entry, in pc order
    for (int i = 0; i < N_TESTS; i++) begin
      @(posedge clk);
      while (!trace_val) begin
        @(posedge clk);
      end
      check_trace(trace, exp_trace[i], check_data[i], ok);
      if (ok) begin
        pass_count++;
        $display("test %0d pc %h: ok", i, exp_trace[i].pc);
      end else begin
        fail_count++;
        $display("test %0d pc %h: trace mismatch", i, exp_trace[i].pc);
      end
    end
    $display("%0d tests passed, %0d failed, %0d request errors", pass_count, fail_count,
             req_errors);
    if (fail_count == 0 && req_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== blimp_core.f ====
verilog/blimp_pkg.sv
verilog/blimp_regfile.sv
verilog/blimp_fetch.sv
verilog/blimp_execute.sv
verilog/blimp_core.sv
sim/blimp_core_chk.sv
sim/blimp_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the Blimp core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module blimp_core_tb -f blimp_core.f -Mdir obj_dir \
  && ./obj_dir/Vblimp_core_tb > sim.log 2>&1 \
  || { echo "Build or simulation error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0
